// ==== Bender.yml ====
package:
  name: cnn_accel

sources:
  - include_dirs:
      - .
    files:
      - cnn_accel_pkg.sv
      - word_fifo.sv
      - apb_host_regs.sv
      - cmd_sequencer.sv
      - mac_engine.sv
      - cnn_accel_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - cnn_accel_props.sv
      - tb_clk_gen.sv
      - cnn_accel_tb.sv

// ==== apb_host_regs.sv ====
`timescale 1ns/1ps
`include "cnn_accel_macros.svh"

module apb_host_regs import cnn_accel_pkg::*; (
	input  logic                                  okClk,
	input  logic                                  i_arst_n,
	input  apb_req_t                              i_apb,
	output apb_rsp_t                              o_apb,
	output logic                                  o_cmd_push,
	output logic                                  o_data_push,
	output logic                                  o_weig_push,
	output logic [31:0]                           o_push_data,
	input  logic [$clog2(`CMD_FIFO_DEPTH+1)-1:0]  i_cmd_count,
	input  logic [$clog2(`OPND_FIFO_DEPTH+1)-1:0] i_data_count,
	input  logic [$clog2(`OPND_FIFO_DEPTH+1)-1:0] i_weig_count,
	input  logic [31:0]                           i_res_rdata,
	input  logic                                  i_res_empty,
	input  logic [$clog2(`RES_FIFO_DEPTH+1)-1:0]  i_res_count,
	output logic                                  o_res_pop,
	input  seq_state_e                            i_seq_state,
	input  logic                                  i_cmd_err,
	input  logic                                  i_done,
	output logic                                  o_op_en,
	output logic                                  o_clear,
	output logic [31:0]                           o_bias,
	output logic                                  o_irq
);

	fifo_stat_t  space_q;
	logic        access;
	logic        wr_acc;
	logic [31:0] rdata;
	logic        err;
	logic        cmd_push, data_push, weig_push, res_pop;

	assign access = i_apb.psel && i_apb.penable;   // access phase, no wait states
	assign wr_acc = access && i_apb.pwrite;

	// ------------------------------
	// address decode
	// ------------------------------
	always_comb begin
		rdata     = '0;
		err       = 1'b0;
		cmd_push  = 1'b0;
		data_push = 1'b0;
		weig_push = 1'b0;
		res_pop   = 1'b0;
		case (i_apb.paddr)
			`REG_CTRL: rdata[0] = o_op_en;
			`REG_CMD: if (i_apb.pwrite) begin
				err      = (i_cmd_count == `CMD_FIFO_DEPTH);
				cmd_push = !err;
			end
			`REG_DATA: if (i_apb.pwrite) begin
				err       = (i_data_count == `OPND_FIFO_DEPTH);
				data_push = !err;
			end
			`REG_WEIG: if (i_apb.pwrite) begin
				err       = (i_weig_count == `OPND_FIFO_DEPTH);
				weig_push = !err;
			end
			`REG_BIAS: rdata = o_bias;
			`REG_RESULT: if (!i_apb.pwrite) begin
				err     = i_res_empty;                  // empty pop reads 0
				res_pop = !i_res_empty;
				if (!i_res_empty)
					rdata = i_res_rdata;
			end
			`REG_STATUS: begin
				rdata[2:0]   = space_q;
				rdata[6:4]   = i_seq_state;
				rdata[8]     = i_cmd_err;
				rdata[20:16] = i_res_count;
			end
			`REG_IRQ: rdata[0] = o_irq;
			default: err = 1'b1;                         // unmapped
		endcase
	end

	assign o_cmd_push    = access && cmd_push;
	assign o_data_push   = access && data_push;
	assign o_weig_push   = access && weig_push;
	assign o_res_pop     = access && res_pop;
	assign o_push_data   = i_apb.pwdata;
	assign o_apb.prdata  = rdata;
	assign o_apb.pslverr = access && err;

	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_op_en <= 1'b0;
			o_clear <= 1'b0;
			o_bias  <= '0;
			o_irq   <= 1'b0;
			space_q <= '1;                                 // fifos start empty
		end else begin
			o_clear <= wr_acc && (i_apb.paddr == `REG_CTRL) && i_apb.pwdata[1];
			if (wr_acc && i_apb.paddr == `REG_CTRL)
				o_op_en <= i_apb.pwdata[0];
			if (wr_acc && i_apb.paddr == `REG_BIAS)
				o_bias <= i_apb.pwdata;
			if (i_done)
				o_irq <= 1'b1;                             // set wins over clear
			else if (wr_acc && i_apb.paddr == `REG_IRQ && i_apb.pwdata[0])
				o_irq <= 1'b0;
			space_q.cmd_space  <= (i_cmd_count <= `CMD_FIFO_DEPTH - `BUF_HEADROOM);
			space_q.data_space <= (i_data_count <= `OPND_FIFO_DEPTH - `BUF_HEADROOM);
			space_q.weig_space <= (i_weig_count <= `OPND_FIFO_DEPTH - `BUF_HEADROOM);
		end
	end

endmodule

// ==== cmd_sequencer.sv ====
`timescale 1ns/1ps

module cmd_sequencer import cnn_accel_pkg::*; (
	input  logic       okClk,
	input  logic       i_arst_n,
	input  logic       i_op_en,
	input  logic       i_clear,
	input  cmd_word_u  i_cmd_word,
	input  logic       i_cmd_empty,
	input  logic       i_eng_done,
	output logic       o_cmd_pop,
	output eng_cmd_t   o_eng_cmd,
	output logic       o_eng_start,
	output logic       o_done,
	output seq_state_e o_state,
	output logic       o_cmd_err
);

	logic hdr_ok;
	logic chan_ok;

	// header and channel checks through the two union views
	assign hdr_ok = !i_cmd_word.hdr.kind &&
		(i_cmd_word.hdr.op == OP_MAC || i_cmd_word.hdr.op == OP_MAX) &&
		(i_cmd_word.hdr.kernel_size != 8'd0);
	assign chan_ok = i_cmd_word.chan.kind && (i_cmd_word.chan.o_count != 16'd0);

	assign o_cmd_pop = (o_state == SEQ_HDR || o_state == SEQ_CHAN) && i_op_en && !i_cmd_empty;
	assign o_done    = (o_state == SEQ_DONE);

	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_state     <= SEQ_IDLE;
			o_eng_start <= 1'b0;
			o_cmd_err   <= 1'b0;
		end else if (i_clear) begin
			o_state     <= SEQ_IDLE;                // error flag survives a clear
			o_eng_start <= 1'b0;
		end else begin
			o_eng_start <= 1'b0;
			case (o_state)
				SEQ_IDLE: if (i_op_en) o_state <= SEQ_HDR;
				SEQ_HDR: begin
					if (!i_op_en)
						o_state <= SEQ_IDLE;
					else if (o_cmd_pop && hdr_ok)
						o_state <= SEQ_CHAN;
					else if (o_cmd_pop)
						o_cmd_err <= 1'b1;              // bad header dropped
				end
				SEQ_CHAN: if (o_cmd_pop) begin
					if (chan_ok) begin
						o_state     <= SEQ_RUN;
						o_eng_start <= 1'b1;
					end else begin
						o_state   <= SEQ_HDR;
						o_cmd_err <= 1'b1;
					end
				end
				SEQ_RUN:  if (i_eng_done) o_state <= SEQ_DONE;
				SEQ_DONE: o_state <= SEQ_HDR;           // back to idle from hdr if op_en low
				default:  o_state <= SEQ_IDLE;
			endcase
		end
	end

	// command fields, header half held until the channel word arrives
	always_ff @(posedge okClk) begin
		if (o_state == SEQ_HDR && o_cmd_pop && hdr_ok) begin
			o_eng_cmd.op          <= i_cmd_word.hdr.op;
			o_eng_cmd.kernel_size <= i_cmd_word.hdr.kernel_size;
		end
		if (o_state == SEQ_CHAN && o_cmd_pop && chan_ok) begin
			o_eng_cmd.o_count <= i_cmd_word.chan.o_count;
			o_eng_cmd.shift   <= i_cmd_word.chan.shift;
		end
	end

endmodule

// ==== cnn_accel.f ====
+incdir+.
cnn_accel_pkg.sv
word_fifo.sv
apb_host_regs.sv
cmd_sequencer.sv
mac_engine.sv
cnn_accel_top.sv
cnn_accel_props.sv
tb_clk_gen.sv
cnn_accel_tb.sv

// ==== cnn_accel_macros.svh ====
`ifndef CNN_ACCEL_MACROS_SVH
`define CNN_ACCEL_MACROS_SVH

// fifo sizes in 32-bit words
`define CMD_FIFO_DEPTH  16
`define OPND_FIFO_DEPTH 64
`define RES_FIFO_DEPTH  16
`define BUF_HEADROOM    4   // margin below full for the space flags

// ------------------------------
// register map
// ------------------------------
`define REG_CTRL   8'h00
`define REG_CMD    8'h04
`define REG_DATA   8'h08
`define REG_WEIG   8'h0C
`define REG_BIAS   8'h10
`define REG_RESULT 8'h14
`define REG_STATUS 8'h18
`define REG_IRQ    8'h1C

`endif

// ==== cnn_accel_pkg.sv ====
package cnn_accel_pkg;

	// ------------------------------
	// host bus
	// ------------------------------
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pslverr;
	} apb_rsp_t;

	// ------------------------------
	// command words
	// ------------------------------
	typedef enum logic [1:0] {
		OP_MAC = 2'd0,
		OP_MAX = 2'd1
	} op_e;

	typedef struct packed {
		logic        kind;          // 0 for a header
		op_e         op;
		logic [7:0]  kernel_size;   // operands per output
		logic [20:0] rsvd;
	} cmd_hdr_t;

	typedef struct packed {
		logic        kind;          // 1 for a channel word
		logic [15:0] o_count;       // outputs per command
		logic [4:0]  shift;         // arithmetic right shift
		logic [9:0]  rsvd;
	} cmd_chan_t;

	// the top bit tells which view applies
	typedef union packed {
		cmd_hdr_t  hdr;
		cmd_chan_t chan;
	} cmd_word_u;

	typedef struct packed {
		op_e         op;
		logic [7:0]  kernel_size;
		logic [15:0] o_count;
		logic [4:0]  shift;
	} eng_cmd_t;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_HDR,
		SEQ_CHAN,
		SEQ_RUN,
		SEQ_DONE
	} seq_state_e;

	typedef struct packed {
		logic cmd_space;
		logic data_space;
		logic weig_space;
	} fifo_stat_t;

endpackage

// ==== cnn_accel_props.sv ====
`timescale 1ns/1ps

module cnn_accel_props import cnn_accel_pkg::*; (
	input logic     okClk,
	input logic     i_arst_n,
	input apb_req_t i_apb,
	input apb_rsp_t i_apb_rsp,
	input logic     i_cmd_push,
	input logic     i_cmd_full,
	input logic     i_data_push,
	input logic     i_data_full,
	input logic     i_weig_push,
	input logic     i_weig_full,
	input logic     i_res_push,
	input logic     i_res_full,
	input logic     i_done,
	input logic     i_irq
);

	// ------------------------------
	// apb phases
	// ------------------------------
	penable_needs_psel: assert property (@(posedge okClk) disable iff (!i_arst_n)
		i_apb.penable |-> i_apb.psel)
		else $error("penable high without psel");

	setup_then_access: assert property (@(posedge okClk) disable iff (!i_arst_n)
		(i_apb.psel && !i_apb.penable) |=> (i_apb.psel && i_apb.penable))
		else $error("setup phase not followed by access phase");

	slverr_in_access: assert property (@(posedge okClk) disable iff (!i_arst_n)
		i_apb_rsp.pslverr |-> (i_apb.psel && i_apb.penable))
		else $error("pslverr outside the access phase");

	// ------------------------------
	// fifos and irq
	// ------------------------------
	no_push_when_full: assert property (@(posedge okClk) disable iff (!i_arst_n)
		!(i_cmd_push && i_cmd_full) && !(i_data_push && i_data_full) &&
		!(i_weig_push && i_weig_full) && !(i_res_push && i_res_full))
		else $error("fifo pushed while full");

	irq_after_done: assert property (@(posedge okClk) disable iff (!i_arst_n)
		$rose(i_irq) |-> $past(i_done))
		else $error("irq rose without a done pulse");

endmodule

// ==== cnn_accel_tb.sv ====
`timescale 1ns/1ps
`include "cnn_accel_macros.svh"

module cnn_accel_tb import cnn_accel_pkg::*; ();

	localparam int IRQ_TIMEOUT = 4000;   // cycles
	localparam int POLL_LIMIT  = 300;    // status reads

	logic        okClk;
	logic        arst_n;
	logic        irq;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic [31:0] cur_bias;
	logic [31:0] data_q[$];              // model copy of the data fifo
	logic [31:0] weig_q[$];
	logic [31:0] exp_q[$];               // expected results in order
	int          errors;
	int          tests;

	tb_clk_gen clk_gen_inst (
		.okClk    (okClk),
		.o_arst_n (arst_n)
	);

	cnn_accel_top cnn_accel_top_inst (
		.okClk    (okClk),
		.i_arst_n (arst_n),
		.i_apb    (apb_req),
		.o_apb    (apb_rsp),
		.o_irq    (irq)
	);

	bind cnn_accel_top cnn_accel_props props_inst (
		.okClk       (okClk),
		.i_arst_n    (i_arst_n),
		.i_apb       (i_apb),
		.i_apb_rsp   (o_apb),
		.i_cmd_push  (cmd_push),
		.i_cmd_full  (cmd_full),
		.i_data_push (data_push),
		.i_data_full (data_full),
		.i_weig_push (weig_push),
		.i_weig_full (weig_full),
		.i_res_push  (res_push),
		.i_res_full  (res_full),
		.i_done      (seq_done),
		.i_irq       (o_irq)
	);

	// ------------------------------
	// reporting
	// ------------------------------
	task automatic report_mismatch(input string tname, input string what,
		input logic [31:0] exp_val, input logic [31:0] act_val);
		$display("[FAIL] %s: %s expected %h, actual %h", tname, what, exp_val, act_val);
		errors++;
	endtask

	task automatic report_problem(input string tname, input string msg);
		$display("[ERROR] %s: %s", tname, msg);
		errors++;
	endtask

	task automatic end_test(input string tname, input int err0);
		tests++;
		$display("test %s finished, %0d error(s)", tname, errors - err0);
	endtask

	// ------------------------------
	// apb access
	// ------------------------------
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(negedge okClk);
		apb_req.psel    = 1'b1;            // setup phase
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge okClk);
		apb_req.penable = 1'b1;            // access phase
		#1;
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(negedge okClk);
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata, output logic err);
		logic [31:0] unused;
		apb_xfer(1'b1, addr, wdata, unused, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata, output logic err);
		apb_xfer(1'b0, addr, 32'h0, rdata, err);
	endtask

	task automatic write_reg(input string tname, input logic [7:0] addr, input logic [31:0] wdata);
		logic err;
		apb_write(addr, wdata, err);
		if (err !== 1'b0)
			report_problem(tname, "write returned pslverr");
	endtask

	task automatic read_reg(input string tname, input logic [7:0] addr, output logic [31:0] rdata);
		logic err;
		apb_read(addr, rdata, err);
		if (err !== 1'b0)
			report_problem(tname, "read returned pslverr");
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic logic [31:0] make_hdr(input op_e op, input logic [7:0] kernel);
		return {1'b0, op, kernel, 21'd0};
	endfunction

	function automatic logic [31:0] make_chan(input logic [15:0] count, input logic [4:0] shift);
		return {1'b1, count, shift, 10'd0};
	endfunction

	task automatic model_command(input op_e op, input int kernel, input int count, input int shift);
		logic signed [31:0] acc;
		logic signed [31:0] d;
		logic signed [31:0] biased;
		logic signed [15:0] a;
		logic signed [15:0] b;
		logic        [31:0] w;
		for (int o = 0; o < count; o++) begin
			acc = 0;
			for (int k = 0; k < kernel; k++) begin
				d = data_q.pop_front();
				if (op == OP_MAX) begin
					if (k == 0 || d > acc)
						acc = d;
				end else begin
					w   = weig_q.pop_front();
					a   = d[15:0];           // low halves only
					b   = w[15:0];
					acc = acc + a * b;
				end
			end
			biased = acc + $signed(cur_bias);
			exp_q.push_back(biased >>> shift);
		end
	endtask

	// ------------------------------
	// stimulus helpers
	// ------------------------------
	task automatic set_bias(input string tname, input logic [31:0] value);
		write_reg(tname, `REG_BIAS, value);
		cur_bias = value;
	endtask

	task automatic push_operands(input string tname, input op_e op, input int n);
		logic [31:0] d;
		logic [31:0] w;
		for (int i = 0; i < n; i++) begin
			d = $urandom;
			write_reg(tname, `REG_DATA, d);
			data_q.push_back(d);
			if (op == OP_MAC) begin
				w = $urandom;
				write_reg(tname, `REG_WEIG, w);
				weig_q.push_back(w);
			end
		end
	endtask

	task automatic send_command(input string tname, input op_e op, input int kernel,
		input int count, input int shift);
		write_reg(tname, `REG_CMD, make_hdr(op, kernel[7:0]));
		write_reg(tname, `REG_CMD, make_chan(count[15:0], shift[4:0]));
		model_command(op, kernel, count, shift);
	endtask

	task automatic wait_irq(input string tname);
		int n;
		n = 0;
		while (irq !== 1'b1 && n < IRQ_TIMEOUT) begin
			@(negedge okClk);
			n++;
		end
		if (irq !== 1'b1)
			report_problem(tname, "timed out waiting for irq");
	endtask

	task automatic clear_irq(input string tname);
		logic [31:0] d;
		write_reg(tname, `REG_IRQ, 32'h1);
		read_reg(tname, `REG_IRQ, d);
		if (d[0] !== 1'b0)
			report_mismatch(tname, "irq after clear", 32'h0, d);
	endtask

	task automatic wait_status(input string tname, input logic [31:0] mask,
		input logic [31:0] value, output logic [31:0] last);
		int n;
		n = 0;
		read_reg(tname, `REG_STATUS, last);
		while ((last & mask) !== value && n < POLL_LIMIT) begin
			read_reg(tname, `REG_STATUS, last);
			n++;
		end
		if ((last & mask) !== value)
			report_problem(tname, "timed out waiting for a status value");
	endtask

	task automatic wait_results(input string tname, input int min_count, output logic [31:0] last);
		int n;
		n = 0;
		read_reg(tname, `REG_STATUS, last);
		while (last[20:16] < min_count && n < POLL_LIMIT) begin
			read_reg(tname, `REG_STATUS, last);
			n++;
		end
		if (last[20:16] < min_count)
			report_problem(tname, "timed out waiting for results");
	endtask

	task automatic check_next_result(input string tname);
		logic [31:0] d;
		logic [31:0] exp_word;
		logic        err;
		apb_read(`REG_RESULT, d, err);
		if (err !== 1'b0)
			report_problem(tname, "result read returned pslverr");
		if (exp_q.size() == 0) begin
			report_problem(tname, "result read with no result expected");
		end else begin
			exp_word = exp_q.pop_front();
			if (d !== exp_word)
				report_mismatch(tname, "result", exp_word, d);
		end
	endtask

	// ------------------------------
	// tests
	// ------------------------------
	task automatic test_reset_regs();
		string       tname;
		int          err0;
		logic [31:0] d;
		logic [31:0] b;
		tname = "reset_regs";
		err0  = errors;
		if (irq !== 1'b0)
			report_mismatch(tname, "irq", 32'h0, irq);
		read_reg(tname, `REG_STATUS, d);
		if (d !== 32'h0000_0007)                    // all space flags, idle, no results
			report_mismatch(tname, "status", 32'h7, d);
		b = $urandom;
		set_bias(tname, b);
		read_reg(tname, `REG_BIAS, d);
		if (d !== b)
			report_mismatch(tname, "bias", b, d);
		write_reg(tname, `REG_CTRL, 32'h1);
		read_reg(tname, `REG_CTRL, d);
		if (d !== 32'h1)
			report_mismatch(tname, "ctrl", 32'h1, d);
		end_test(tname, err0);
	endtask

	task automatic test_single_mac();
		string tname;
		int    err0;
		tname = "single_mac";
		err0  = errors;
		write_reg(tname, `REG_CTRL, 32'h1);
		set_bias(tname, $urandom);
		push_operands(tname, OP_MAC, 8);
		send_command(tname, OP_MAC, 8, 1, 2);
		wait_irq(tname);
		check_next_result(tname);
		clear_irq(tname);
		end_test(tname, err0);
	endtask

	task automatic test_max_then_mac();
		string       tname;
		int          err0;
		logic [31:0] d;
		tname = "max_then_mac";
		err0  = errors;
		set_bias(tname, $urandom);
		push_operands(tname, OP_MAX, 12);
		send_command(tname, OP_MAX, 4, 3, 1);
		wait_irq(tname);
		clear_irq(tname);
		push_operands(tname, OP_MAC, 10);
		send_command(tname, OP_MAC, 5, 2, 0);
		wait_irq(tname);
		clear_irq(tname);
		read_reg(tname, `REG_STATUS, d);
		if (d[20:16] !== 5'd5)
			report_mismatch(tname, "result count", 32'd5, d[20:16]);
		for (int i = 0; i < 5; i++)
			check_next_result(tname);
		end_test(tname, err0);
	endtask

	task automatic test_back_pressure();
		string       tname;
		int          err0;
		logic [31:0] d;
		tname = "back_pressure";
		err0  = errors;
		set_bias(tname, $urandom);
		push_operands(tname, OP_MAC, 40);
		send_command(tname, OP_MAC, 2, 20, 3);
		wait_results(tname, `RES_FIFO_DEPTH, d);  // fifo fills, engine stalls
		if (d[6:4] !== SEQ_RUN)
			report_mismatch(tname, "state while stalled", SEQ_RUN, d[6:4]);
		if (irq !== 1'b0)
			report_mismatch(tname, "irq while stalled", 32'h0, irq);
		for (int i = 0; i < 20; i++) begin
			wait_results(tname, 1, d);
			check_next_result(tname);
		end
		wait_irq(tname);
		clear_irq(tname);
		read_reg(tname, `REG_STATUS, d);
		if (d[20:16] !== 5'd0)                     // no extra results after the drain
			report_mismatch(tname, "result count after drain", 32'h0, d[20:16]);
		end_test(tname, err0);
	endtask

	task automatic test_errors();
		string       tname;
		int          err0;
		logic [31:0] d;
		logic        err;
		tname = "errors";
		err0  = errors;
		write_reg(tname, `REG_CTRL, 32'h0);        // commands pile up
		apb_read(`REG_RESULT, d, err);
		if (err !== 1'b1)
			report_mismatch(tname, "empty pop pslverr", 32'h1, err);
		if (d !== 32'h0)
			report_mismatch(tname, "empty pop data", 32'h0, d);
		for (int i = 0; i < `CMD_FIFO_DEPTH; i++)
			write_reg(tname, `REG_CMD, $urandom);
		apb_write(`REG_CMD, $urandom, err);
		if (err !== 1'b1)
			report_mismatch(tname, "full push pslverr", 32'h1, err);
		read_reg(tname, `REG_STATUS, d);
		if (d[2] !== 1'b0)
			report_mismatch(tname, "cmd space flag", 32'h0, d[2]);
		apb_read(8'h20, d, err);
		if (err !== 1'b1)
			report_mismatch(tname, "unmapped read pslverr", 32'h1, err);
		apb_write(8'h24, 32'h1, err);
		if (err !== 1'b1)
			report_mismatch(tname, "unmapped write pslverr", 32'h1, err);
		write_reg(tname, `REG_CTRL, 32'h2);        // flush the full command fifo
		write_reg(tname, `REG_CTRL, 32'h1);
		write_reg(tname, `REG_CMD, make_hdr(OP_MAC, 8'd4) | 32'h8000_0000);  // kind 1
		wait_status(tname, 32'h100, 32'h100, d);
		end_test(tname, err0);
	endtask

	task automatic test_soft_clear();
		string       tname;
		int          err0;
		logic [31:0] d;
		tname = "soft_clear";
		err0  = errors;
		write_reg(tname, `REG_CTRL, 32'h1);
		set_bias(tname, $urandom);
		push_operands(tname, OP_MAC, 3);
		write_reg(tname, `REG_CMD, make_hdr(OP_MAC, 8'd4));   // header only
		wait_status(tname, 32'h70, {25'd0, SEQ_CHAN, 4'd0}, d);
		write_reg(tname, `REG_CTRL, 32'h2);        // clear, op_en off
		data_q.delete();
		weig_q.delete();
		read_reg(tname, `REG_STATUS, d);
		if ((d & 32'h001F_0077) !== 32'h7)
			report_mismatch(tname, "status after clear", 32'h7, d & 32'h001F_0077);
		write_reg(tname, `REG_CTRL, 32'h1);
		push_operands(tname, OP_MAC, 4);
		send_command(tname, OP_MAC, 4, 1, 1);
		wait_irq(tname);
		check_next_result(tname);
		clear_irq(tname);
		end_test(tname, err0);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		int n;
		apb_req  = '0;
		cur_bias = '0;
		errors   = 0;
		tests    = 0;
		void'($urandom(32'h8efe_f327));
		n = 0;
		while (arst_n !== 1'b1 && n < 100) begin
			@(negedge okClk);
			n++;
		end
		if (arst_n !== 1'b1)
			report_problem("startup", "reset was never released");
		test_reset_regs();
		test_single_mac();
		test_max_then_mac();
		test_back_pressure();
		test_errors();
		test_soft_clear();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== cnn_accel_top.sv ====
`timescale 1ns/1ps
`include "cnn_accel_macros.svh"

module cnn_accel_top import cnn_accel_pkg::*; (
	input  logic     okClk,
	input  logic     i_arst_n,
	input  apb_req_t i_apb,
	output apb_rsp_t o_apb,
	output logic     o_irq
);

	logic                                  cmd_push, data_push, weig_push, res_push;
	logic                                  cmd_pop, data_pop, weig_pop, res_pop;
	logic                                  cmd_empty, data_empty, weig_empty, res_empty;
	logic                                  cmd_full, data_full, weig_full, res_full;
	logic [31:0]                           push_data, data_word, weig_word;
	logic [31:0]                           res_word, res_rdata, bias;
	logic [$clog2(`CMD_FIFO_DEPTH+1)-1:0]  cmd_count;
	logic [$clog2(`OPND_FIFO_DEPTH+1)-1:0] data_count, weig_count;
	logic [$clog2(`RES_FIFO_DEPTH+1)-1:0]  res_count;
	logic                                  op_en, clear, seq_done, cmd_err, eng_start, eng_done;
	cmd_word_u                             cmd_word;
	eng_cmd_t                              eng_cmd;
	seq_state_e                            seq_state;

	// ------------------------------
	// host side
	// ------------------------------
	apb_host_regs regs_inst (
		.okClk        (okClk),
		.i_arst_n     (i_arst_n),
		.i_apb        (i_apb),
		.o_apb        (o_apb),
		.o_cmd_push   (cmd_push),
		.o_data_push  (data_push),
		.o_weig_push  (weig_push),
		.o_push_data  (push_data),
		.i_cmd_count  (cmd_count),
		.i_data_count (data_count),
		.i_weig_count (weig_count),
		.i_res_rdata  (res_rdata),
		.i_res_empty  (res_empty),
		.i_res_count  (res_count),
		.o_res_pop    (res_pop),
		.i_seq_state  (seq_state),
		.i_cmd_err    (cmd_err),
		.i_done       (seq_done),
		.o_op_en      (op_en),
		.o_clear      (clear),
		.o_bias       (bias),
		.o_irq        (o_irq)
	);

	word_fifo #(.DEPTH(`CMD_FIFO_DEPTH)) cmd_fifo (
		.okClk (okClk), .i_arst_n (i_arst_n), .i_flush (clear),
		.i_push (cmd_push), .i_wdata (push_data), .i_pop (cmd_pop),
		.o_rdata (cmd_word), .o_empty (cmd_empty), .o_full (cmd_full), .o_count (cmd_count)
	);

	word_fifo #(.DEPTH(`OPND_FIFO_DEPTH)) data_fifo (
		.okClk (okClk), .i_arst_n (i_arst_n), .i_flush (clear),
		.i_push (data_push), .i_wdata (push_data), .i_pop (data_pop),
		.o_rdata (data_word), .o_empty (data_empty), .o_full (data_full), .o_count (data_count)
	);

	word_fifo #(.DEPTH(`OPND_FIFO_DEPTH)) weig_fifo (
		.okClk (okClk), .i_arst_n (i_arst_n), .i_flush (clear),
		.i_push (weig_push), .i_wdata (push_data), .i_pop (weig_pop),
		.o_rdata (weig_word), .o_empty (weig_empty), .o_full (weig_full), .o_count (weig_count)
	);

	// ------------------------------
	// processing
	// ------------------------------
	cmd_sequencer seq_inst (
		.okClk       (okClk),
		.i_arst_n    (i_arst_n),
		.i_op_en     (op_en),
		.i_clear     (clear),
		.i_cmd_word  (cmd_word),
		.i_cmd_empty (cmd_empty),
		.i_eng_done  (eng_done),
		.o_cmd_pop   (cmd_pop),
		.o_eng_cmd   (eng_cmd),
		.o_eng_start (eng_start),
		.o_done      (seq_done),
		.o_state     (seq_state),
		.o_cmd_err   (cmd_err)
	);

	mac_engine eng_inst (
		.okClk        (okClk),
		.i_arst_n     (i_arst_n),
		.i_clear      (clear),
		.i_start      (eng_start),
		.i_cmd        (eng_cmd),
		.i_bias       (bias),
		.i_data       (data_word),
		.i_data_empty (data_empty),
		.i_weig       (weig_word),
		.i_weig_empty (weig_empty),
		.i_res_full   (res_full),
		.o_data_pop   (data_pop),
		.o_weig_pop   (weig_pop),
		.o_res_push   (res_push),
		.o_res_data   (res_word),
		.o_done       (eng_done)
	);

	word_fifo #(.DEPTH(`RES_FIFO_DEPTH)) res_fifo (
		.okClk (okClk), .i_arst_n (i_arst_n), .i_flush (clear),
		.i_push (res_push), .i_wdata (res_word), .i_pop (res_pop),
		.o_rdata (res_rdata), .o_empty (res_empty), .o_full (res_full), .o_count (res_count)
	);

endmodule

// ==== mac_engine.sv ====
`timescale 1ns/1ps

module mac_engine import cnn_accel_pkg::*; (
	input  logic        okClk,
	input  logic        i_arst_n,
	input  logic        i_clear,
	input  logic        i_start,
	input  eng_cmd_t    i_cmd,
	input  logic [31:0] i_bias,
	input  logic [31:0] i_data,
	input  logic        i_data_empty,
	input  logic [31:0] i_weig,
	input  logic        i_weig_empty,
	input  logic        i_res_full,
	output logic        o_data_pop,
	output logic        o_weig_pop,
	output logic        o_res_push,
	output logic [31:0] o_res_data,
	output logic        o_done
);

	eng_cmd_t           cmd_q;
	logic               busy_q, issued_q, res_valid_q;
	logic [7:0]         opnd_cnt_q;
	logic [15:0]        out_cnt_q;
	logic signed [31:0] acc_q, acc_next, prod, biased;
	logic               ops_ready, pop, last_opnd, last_out;

	// ------------------------------
	// operand handshake
	// ------------------------------
	assign ops_ready  = (cmd_q.op == OP_MAX) ? !i_data_empty : (!i_data_empty && !i_weig_empty);
	assign o_res_push = res_valid_q && !i_res_full;
	assign pop        = busy_q && !issued_q && ops_ready && (!res_valid_q || !i_res_full);
	assign o_data_pop = pop;
	assign o_weig_pop = pop && (cmd_q.op == OP_MAC);   // max reads data only
	assign last_opnd  = (opnd_cnt_q == cmd_q.kernel_size - 8'd1);
	assign last_out   = (out_cnt_q == cmd_q.o_count - 16'd1);

	// ------------------------------
	// datapath
	// ------------------------------
	assign prod = $signed(i_data[15:0]) * $signed(i_weig[15:0]);

	always_comb begin
		if (cmd_q.op == OP_MAX) begin
			if (opnd_cnt_q == 8'd0 || $signed(i_data) > acc_q)
				acc_next = i_data;
			else
				acc_next = acc_q;
		end else begin
			acc_next = (opnd_cnt_q == 8'd0) ? prod : acc_q + prod;   // wraps at 32 bits
		end
	end

	assign biased = acc_next + $signed(i_bias);

	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy_q      <= 1'b0;
			issued_q    <= 1'b0;
			res_valid_q <= 1'b0;
			o_done      <= 1'b0;
			opnd_cnt_q  <= '0;
			out_cnt_q   <= '0;
		end else if (i_clear) begin
			busy_q      <= 1'b0;
			issued_q    <= 1'b0;
			res_valid_q <= 1'b0;
			o_done      <= 1'b0;
			opnd_cnt_q  <= '0;
			out_cnt_q   <= '0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				busy_q     <= 1'b1;
				issued_q   <= 1'b0;
				opnd_cnt_q <= '0;
				out_cnt_q  <= '0;
			end else begin
				if (pop && last_opnd) begin
					opnd_cnt_q <= '0;
					out_cnt_q  <= out_cnt_q + 16'd1;
					issued_q   <= last_out;             // stop popping after final output
				end else if (pop) begin
					opnd_cnt_q <= opnd_cnt_q + 8'd1;
				end
				if (pop && last_opnd)
					res_valid_q <= 1'b1;
				else if (o_res_push)
					res_valid_q <= 1'b0;
				if (busy_q && issued_q && o_res_push) begin
					busy_q   <= 1'b0;                   // last result left the stage
					issued_q <= 1'b0;
					o_done   <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge okClk) begin
		if (i_start)
			cmd_q <= i_cmd;
		if (pop)
			acc_q <= acc_next;
		if (pop && last_opnd)
			o_res_data <= biased >>> cmd_q.shift;    // held while result fifo full
	end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic okClk,
	output logic o_arst_n
);

	initial begin
		okClk = 1'b0;
		forever #10 okClk = ~okClk;   // 20 ns period
	end

	initial begin
		o_arst_n = 1'b0;
		repeat (8) @(posedge okClk);  // reset held for 8 cycles
		@(negedge okClk);
		o_arst_n = 1'b1;
	end

endmodule

// ==== word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo #(
	parameter int DEPTH = 16
) (
	input  logic                           okClk,
	input  logic                           i_arst_n,
	input  logic                           i_flush,
	input  logic                           i_push,
	input  logic [31:0]                    i_wdata,
	input  logic                           i_pop,
	output logic [31:0]                    o_rdata,
	output logic                           o_empty,
	output logic                           o_full,
	output logic [$clog2(DEPTH+1)-1:0]     o_count
);

	logic [31:0]              mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(DEPTH)-1:0] rd_ptr_q;
	logic                     do_push;
	logic                     do_pop;

	assign o_empty = (o_count == '0);
	assign o_full  = (o_count == DEPTH);
	assign do_push = i_push && !o_full;      // push on full is dropped
	assign do_pop  = i_pop && !o_empty;
	assign o_rdata = mem[rd_ptr_q];          // show-ahead head word

	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			o_count  <= '0;
		end else if (i_flush) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			o_count  <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps, depth is a power of two
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (do_push && !do_pop)
				o_count <= o_count + 1'b1;
			else if (do_pop && !do_push)
				o_count <= o_count - 1'b1;
		end
	end

	always_ff @(posedge okClk) begin
		if (do_push)
			mem[wr_ptr_q] <= i_wdata;
	end

endmodule
